// File: decode_stage_top.f
rv64_decode_pkg.sv
fetch_packet_capture.sv
instr_decoder.sv
decode_serializer.sv
decode_stage_top.sv
decode_stage_assert.sv
tb_decode_stage.sv

// File: decode_testdata.txt
// Columns: instruction _ exception flag _ exception code _ expected decode word, all hex
// Four lines make one fetch packet, lane 0 first
00b50533_0_0_a1000000 // add x10, x10, x11
407302b3_0_0_a1000400 // sub x5, x6, x7
0051009b_0_0_a1010100 // addiw x1, x2, 5
42125193_0_0_a1001100 // srai x3, x4, 33
007322bb_0_0_00000040 // slt with W opcode, illegal
123452b7_0_0_a1002900 // lui x5, 0x12345
00001317_0_0_a1000300 // auipc x6, 1
02c58533_0_0_89004000 // mul x10, x11, x12
02c5c53b_0_0_84014400 // divw x10, x11, x12
023160b3_0_0_84004c00 // rem x1, x2, x3
008000ef_0_0_c1006000 // jal x1, 8
00008067_0_0_c1006480 // jalr x0, 0(x1)
00208863_0_0_c0006800 // beq x1, x2, 16
01033283_0_0_91889800 // ld x5, 16(x6)
00732423_0_0_9048a800 // sw x7, 8(x6)
0ff0000f_0_0_00000000 // fence
0000100f_0_0_9042bc00 // fence.i
00000073_0_0_8206c000 // ecall
300110f3_0_0_8336e000 // csrrw x1, mstatus, x2
12208073_0_0_8206d800 // sfence.vma x1, x2
0021a0af_0_0_00000040 // amoadd.w, illegal
0000007f_0_0_00000040 // unknown opcode
ffffffff_1_1_00000010 // page fault on an illegal word
00b50533_1_2_00000008 // itlb miss on add

// File: tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage
    import rv64_decode_pkg::*;
();

    localparam int lanes_p       = 4;
    localparam int num_entries   = 24;
    localparam int num_pkts      = num_entries / lanes_p;
    localparam int clk_period    = 20;
    localparam int timeout_ns    = (num_entries * 12 + 100) * clk_period;
    localparam int drain_cycles  = 20;

    logic         clk;
    logic         rst_n;
    logic         in_req;
    fetch_entry_s in_pkt [lanes_p];
    logic         in_ack;
    logic         out_req;
    decode_s      out_dec;
    logic         out_ack;

    // Instruction, exception flag, exception code, expected decode word
    logic [71:0]  test_vec [num_entries];
    integer       seed;
    int           err_cnt   = 0;
    int           chk_cnt   = 0;
    int           req_cnt   = 0;
    logic         req_seen  = 1'b0;

    decode_stage_top #(
        .lanes_p (lanes_p)
    ) u_decode_stage_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_pkt  (in_pkt),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_dec (out_dec),
        .out_ack (out_ack)
    );

    bind decode_stage_top decode_stage_assert u_decode_stage_assert (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Counts entries handed out by the stage
    always @(negedge clk) begin
        if (out_req && !req_seen) begin
            req_cnt++;
        end
        req_seen = out_req;
    end

    function automatic fetch_entry_s entry_of(input int idx);
        fetch_entry_s e;
        e.instr    = rv64_instr_s'(test_vec[idx][71:40]);
        e.exc_v    = test_vec[idx][36];
        e.exc_code = fe_exc_e'(test_vec[idx][33:32]);
        return e;
    endfunction

    function automatic string packet_label(input int p);
        case (p)
            0:       return "integer register and immediate ops";
            1:       return "word funct, upper immediates, multiply";
            2:       return "divide, remainder, jumps";
            3:       return "branch, load, store, fence";
            4:       return "fence.i, system, csr";
            5:       return "illegal opcodes and front-end faults";
            default: return "extra packet";
        endcase
    endfunction

    // Next packet goes out as soon as the previous ack has fallen
    task automatic drive_packets();
        for (int p = 0; p < num_pkts; p++) begin
            @(posedge clk);
            for (int l = 0; l < lanes_p; l++) begin
                in_pkt[l] <= entry_of(p * lanes_p + l);
            end
            in_req <= 1'b1;
            @(negedge clk);
            while (!in_ack) @(negedge clk);
            @(posedge clk);
            in_req <= 1'b0;
            @(negedge clk);
            while (in_ack) @(negedge clk);
        end
    endtask

    task automatic collect_entries();
        int          delay;
        int          errs_before;
        logic [31:0] exp;
        logic [31:0] act;
        errs_before = 0;
        for (int idx = 0; idx < num_entries; idx++) begin
            @(negedge clk);
            while (!out_req) @(negedge clk);
            exp = test_vec[idx][31:0];
            act = out_dec;
            chk_cnt++;
            assert (act === exp) else begin
                $display("error: out_dec entry %0d expected %08h actual %08h", idx, exp, act);
                err_cnt++;
            end
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            out_ack <= 1'b1;
            @(negedge clk);
            while (out_req) @(negedge clk);
            @(posedge clk);
            out_ack <= 1'b0;
            if (idx % lanes_p == lanes_p - 1) begin
                $display("test %0d (%s): %0d entries, %0d errors", idx / lanes_p,
                         packet_label(idx / lanes_p), lanes_p, err_cnt - errs_before);
                errs_before = err_cnt;
            end
        end
    endtask

    initial begin
        seed    = 32'h7adc;
        rst_n   = 1'b0;
        in_req  = 1'b0;
        out_ack = 1'b0;
        for (int l = 0; l < lanes_p; l++) begin
            in_pkt[l] = '0;
        end
        $readmemh("decode_testdata.txt", test_vec);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        fork
            drive_packets();
            collect_entries();
        join
        // Any entry beyond the last packet shows up here
        repeat (drain_cycles) @(negedge clk);
        chk_cnt++;
        assert (req_cnt == num_pkts * lanes_p) else begin
            $display("entry count %0d does not match %0d packets of %0d lanes",
                     req_cnt, num_pkts, lanes_p);
            err_cnt++;
        end
        err_cnt += u_decode_stage_top.u_decode_stage_assert.fail_cnt;
        $display("checks %0d, errors %0d, entries %0d of %0d",
                 chk_cnt, err_cnt, req_cnt, num_entries);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: only %0d of %0d entries came out of the stage", req_cnt, num_entries);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: decode_stage_assert.sv
`timescale 1ns/100ps

module decode_stage_assert
    import rv64_decode_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    in_req,
    input logic    in_ack,
    input logic    out_req,
    input logic    out_ack,
    input decode_s out_dec
);

    int fail_cnt = 0;

    // Output request stays up until the receiver answers
    a_out_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req
    ) else begin
        $error("out_req dropped before out_ack was seen");
        fail_cnt++;
    end

    a_out_dec_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req |=> !out_req || $stable(out_dec)
    ) else begin
        $error("out_dec changed while out_req was high");
        fail_cnt++;
    end

    a_in_ack_rise: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req)
    ) else begin
        $error("in_ack rose without a pending in_req");
        fail_cnt++;
    end

    // Both handshakes idle while reset is held
    a_reset_idle: assert property (
        @(posedge clk)
        !rst_n |=> !in_ack && !out_req
    ) else begin
        $error("in_ack or out_req high during reset");
        fail_cnt++;
    end

endmodule

// File: decode_stage_top.sv
`timescale 1ns/100ps

module decode_stage_top
    import rv64_decode_pkg::*;
#(
    parameter int lanes_p = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_req,
    input  fetch_entry_s in_pkt [lanes_p],
    output logic         in_ack,
    output logic         out_req,
    output decode_s      out_dec,
    input  logic         out_ack
);

    fetch_entry_s pkt [lanes_p];
    logic         pkt_v;
    logic         take;
    decode_s      lane_dec [lanes_p];

    fetch_packet_capture #(
        .lanes_p (lanes_p)
    ) u_fetch_packet_capture (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_req (in_req),
        .in_pkt (in_pkt),
        .take   (take),
        .in_ack (in_ack),
        .pkt    (pkt),
        .pkt_v  (pkt_v)
    );

    for (genvar i = 0; i < lanes_p; i++) begin : g_lane
        instr_decoder u_instr_decoder (
            .clk      (clk),
            .rst_n    (rst_n),
            .entry    (pkt[i]),
            .take     (take),
            .lane_dec (lane_dec[i])
        );
    end

    decode_serializer #(
        .lanes_p (lanes_p)
    ) u_decode_serializer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pkt_v    (pkt_v),
        .lane_dec (lane_dec),
        .out_ack  (out_ack),
        .take     (take),
        .out_req  (out_req),
        .out_dec  (out_dec)
    );

endmodule

// File: decode_serializer.sv
`timescale 1ns/100ps

module decode_serializer
    import rv64_decode_pkg::*;
#(
    parameter int lanes_p = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pkt_v,
    input  decode_s lane_dec [lanes_p],
    input  logic    out_ack,
    output logic    take,
    output logic    out_req,
    output decode_s out_dec
);

    localparam int cnt_w = (lanes_p > 1) ? $clog2(lanes_p) : 1;

    logic             full;
    logic [cnt_w-1:0] lane;
    logic             last_lane;
    logic             lane_done;

    assign last_lane = (lane == cnt_w'(lanes_p - 1));

    // Req dropped and ack back low for the current lane
    assign lane_done = full && !out_req && !out_ack;

    // Reload as the last lane returns, so packets follow back to back
    assign take    = pkt_v && (!full || (lane_done && last_lane));
    assign out_dec = lane_dec[lane];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full    <= 1'b0;
            lane    <= '0;
            out_req <= 1'b0;
        end else if (take) begin
            full    <= 1'b1;
            lane    <= '0;
            out_req <= 1'b1;
        end else if (out_req && out_ack) begin
            out_req <= 1'b0;
        end else if (lane_done) begin
            if (last_lane) begin
                full <= 1'b0;
            end else begin
                lane    <= lane + 1'b1;
                out_req <= 1'b1;
            end
        end
    end

endmodule

// File: instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder
    import rv64_decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  fetch_entry_s entry,
    input  logic         take,
    output decode_s      lane_dec
);

    rv64_instr_s instr;
    decode_s     dec;
    logic        illegal;
    logic        is_w;
    logic        w_bad;
    logic [6:0]  shift_f7;

    assign instr = entry.instr;
    assign is_w  = (instr.opcode == op_32_op) || (instr.opcode == op_imm_32_op);

    // W forms keep only add/sub and the shifts
    assign w_bad = is_w && !(instr.funct3 inside {f3_add, f3_sll, f3_srl});

    // RV64 shift immediates take a 6-bit shamt, so funct7[0] is shamt[5]
    assign shift_f7 = is_w ? instr.funct7 : {instr.funct7[6:1], 1'b0};

    always_comb begin
        dec         = '0;
        dec.instr_v = 1'b1;
        illegal     = 1'b0;

        unique case (instr.opcode)
            op_op, op_32_op: begin
                dec.opw_v    = is_w;
                dec.src1_sel = e_src1_is_rs1;
                dec.src2_sel = e_src2_is_rs2;
                unique case (instr.funct7)
                    f7_base: begin
                        dec.pipe_sel.int_v = 1'b1;
                        illegal            = w_bad;
                        unique case (instr.funct3)
                            f3_add:  dec.fu_op = e_int_op_add;
                            f3_sll:  dec.fu_op = e_int_op_sll;
                            f3_slt:  dec.fu_op = e_int_op_slt;
                            f3_sltu: dec.fu_op = e_int_op_sltu;
                            f3_xor:  dec.fu_op = e_int_op_xor;
                            f3_srl:  dec.fu_op = e_int_op_srl;
                            f3_or:   dec.fu_op = e_int_op_or;
                            f3_and:  dec.fu_op = e_int_op_and;
                        endcase
                    end
                    f7_alt: begin
                        dec.pipe_sel.int_v = 1'b1;
                        if (instr.funct3 == f3_add) begin
                            dec.fu_op = e_int_op_sub;
                        end else if (instr.funct3 == f3_srl) begin
                            dec.fu_op = e_int_op_sra;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    f7_muldiv: begin
                        // Divide and remainder go to the long-latency pipe
                        if (instr.funct3 == f3_mul) begin
                            dec.pipe_sel.mul_v = 1'b1;
                        end else begin
                            dec.pipe_sel.long_v = 1'b1;
                        end
                        unique case (instr.funct3)
                            f3_mul:  dec.fu_op = e_mul_op_mul;
                            f3_div:  dec.fu_op = e_mul_op_div;
                            f3_divu: dec.fu_op = e_mul_op_divu;
                            f3_rem:  dec.fu_op = e_mul_op_rem;
                            f3_remu: dec.fu_op = e_mul_op_remu;
                            default: illegal = 1'b1;
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
                // Long ops write back out of band
                dec.irf_w_v = ~dec.pipe_sel.long_v;
            end
            op_imm_op, op_imm_32_op: begin
                dec.pipe_sel.int_v = 1'b1;
                dec.irf_w_v        = 1'b1;
                dec.opw_v          = is_w;
                dec.src1_sel       = e_src1_is_rs1;
                dec.src2_sel       = e_src2_is_imm;
                illegal            = w_bad;
                unique case (instr.funct3)
                    f3_add:  dec.fu_op = e_int_op_add;
                    f3_slt:  dec.fu_op = e_int_op_slt;
                    f3_sltu: dec.fu_op = e_int_op_sltu;
                    f3_xor:  dec.fu_op = e_int_op_xor;
                    f3_or:   dec.fu_op = e_int_op_or;
                    f3_and:  dec.fu_op = e_int_op_and;
                    f3_sll: begin
                        dec.fu_op = e_int_op_sll;
                        if (shift_f7 != f7_base) begin
                            illegal = 1'b1;
                        end
                    end
                    f3_srl: begin
                        if (shift_f7 == f7_base) begin
                            dec.fu_op = e_int_op_srl;
                        end else if (shift_f7 == f7_alt) begin
                            dec.fu_op = e_int_op_sra;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            lui_op: begin
                dec.pipe_sel.int_v = 1'b1;
                dec.irf_w_v        = 1'b1;
                dec.fu_op          = e_int_op_pass_src2;
                dec.src2_sel       = e_src2_is_imm;
            end
            auipc_op: begin
                dec.pipe_sel.int_v = 1'b1;
                dec.irf_w_v        = 1'b1;
                dec.fu_op          = e_int_op_add;
                dec.src1_sel       = e_src1_is_pc;
                dec.src2_sel       = e_src2_is_imm;
            end
            jal_op: begin
                dec.pipe_sel.ctrl_v = 1'b1;
                dec.irf_w_v         = 1'b1;
                dec.fu_op           = e_ctrl_op_jal;
                dec.baddr_sel       = e_baddr_is_pc;
            end
            jalr_op: begin
                dec.pipe_sel.ctrl_v = 1'b1;
                dec.irf_w_v         = 1'b1;
                dec.fu_op           = e_ctrl_op_jalr;
                dec.baddr_sel       = e_baddr_is_rs1;
                illegal             = (instr.funct3 != f3_jalr);
            end
            branch_op: begin
                dec.pipe_sel.ctrl_v = 1'b1;
                dec.baddr_sel       = e_baddr_is_pc;
                unique case (instr.funct3)
                    f3_beq:  dec.fu_op = e_ctrl_op_beq;
                    f3_bne:  dec.fu_op = e_ctrl_op_bne;
                    f3_blt:  dec.fu_op = e_ctrl_op_blt;
                    f3_bge:  dec.fu_op = e_ctrl_op_bge;
                    f3_bltu: dec.fu_op = e_ctrl_op_bltu;
                    f3_bgeu: dec.fu_op = e_ctrl_op_bgeu;
                    default: illegal = 1'b1;
                endcase
            end
            load_op: begin
                dec.pipe_sel.mem_v = 1'b1;
                dec.irf_w_v        = 1'b1;
                dec.dcache_r_v     = 1'b1;
                dec.mem_v          = 1'b1;
                unique case (instr.funct3)
                    f3_lb:   dec.fu_op = e_lb;
                    f3_lh:   dec.fu_op = e_lh;
                    f3_lw:   dec.fu_op = e_lw;
                    f3_ld:   dec.fu_op = e_ld;
                    f3_lbu:  dec.fu_op = e_lbu;
                    f3_lhu:  dec.fu_op = e_lhu;
                    f3_lwu:  dec.fu_op = e_lwu;
                    default: illegal = 1'b1;
                endcase
            end
            store_op: begin
                dec.pipe_sel.mem_v = 1'b1;
                dec.dcache_w_v     = 1'b1;
                dec.mem_v          = 1'b1;
                unique case (instr.funct3)
                    f3_sb:   dec.fu_op = e_sb;
                    f3_sh:   dec.fu_op = e_sh;
                    f3_sw:   dec.fu_op = e_sw;
                    f3_sd:   dec.fu_op = e_sd;
                    default: illegal = 1'b1;
                endcase
            end
            misc_mem_op: begin
                if (instr.funct3 == f3_fence) begin
                    // Memory is already ordered in this core
                    dec = '0;
                end else if (instr.funct3 == f3_fence_i) begin
                    dec.pipe_sel.mem_v = 1'b1;
                    dec.dcache_w_v     = 1'b1;
                    dec.serial_v       = 1'b1;
                    dec.fu_op          = e_fencei;
                end else begin
                    illegal = 1'b1;
                end
            end
            system_op: begin
                dec.pipe_sel.sys_v = 1'b1;
                dec.csr_v          = 1'b1;
                dec.serial_v       = 1'b1;
                if (instr.funct3 == f3_priv) begin
                    if (instr == ecall_instr) begin
                        dec.fu_op = e_ecall;
                    end else if (instr == ebreak_instr) begin
                        dec.fu_op = e_ebreak;
                    end else if (instr == dret_instr) begin
                        dec.fu_op = e_dret;
                    end else if (instr == mret_instr) begin
                        dec.fu_op = e_mret;
                    end else if (instr == sret_instr) begin
                        dec.fu_op = e_sret;
                    end else if (instr == wfi_instr) begin
                        dec.fu_op = e_wfi;
                    end else if (instr.funct7 == f7_sfence_vma && instr.rd == '0) begin
                        dec.fu_op = e_sfence_vma;
                    end else begin
                        illegal = 1'b1;
                    end
                end else begin
                    dec.irf_w_v = 1'b1;
                    dec.csr_r_v = 1'b1;
                    dec.csr_w_v = 1'b1;
                    unique case (instr.funct3)
                        f3_csrrw:  dec.fu_op = e_csrrw;
                        f3_csrrs:  dec.fu_op = e_csrrs;
                        f3_csrrc:  dec.fu_op = e_csrrc;
                        f3_csrrwi: dec.fu_op = e_csrrwi;
                        f3_csrrsi: dec.fu_op = e_csrrsi;
                        f3_csrrci: dec.fu_op = e_csrrci;
                        default:   illegal = 1'b1;
                    endcase
                end
            end
            // No atomics in this core
            amo_op:  illegal = 1'b1;
            default: illegal = 1'b1;
        endcase

        // Front-end faults win over anything decoded
        if (entry.exc_v) begin
            dec = '0;
            case (entry.exc_code)
                e_instr_access_fault: dec.instr_access_fault = 1'b1;
                e_instr_page_fault:   dec.instr_page_fault   = 1'b1;
                e_itlb_miss:          dec.itlb_miss          = 1'b1;
            endcase
        end else if (illegal) begin
            dec               = '0;
            dec.illegal_instr = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_dec <= '0;
        end else if (take) begin
            lane_dec <= dec;
        end
    end

endmodule

// File: fetch_packet_capture.sv
`timescale 1ns/100ps

module fetch_packet_capture
    import rv64_decode_pkg::*;
#(
    parameter int lanes_p = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_req,
    input  fetch_entry_s in_pkt [lanes_p],
    input  logic         take,
    output logic         in_ack,
    output fetch_entry_s pkt [lanes_p],
    output logic         pkt_v
);

    logic accept;

    // Fresh request, last ack returned and the holding slot free
    assign accept = in_req && !in_ack && !pkt_v;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
            pkt_v  <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
            pkt_v  <= 1'b1;
        end else begin
            if (!in_req) begin
                in_ack <= 1'b0;
            end
            if (take) begin
                pkt_v <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt <= in_pkt;
        end
    end

endmodule

// File: rv64_decode_pkg.sv
package rv64_decode_pkg;

    localparam int instr_width = 32;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv64_instr_s;

    // Major opcodes
    localparam logic [6:0] op_op        = 7'b0110011;
    localparam logic [6:0] op_32_op     = 7'b0111011;
    localparam logic [6:0] op_imm_op    = 7'b0010011;
    localparam logic [6:0] op_imm_32_op = 7'b0011011;
    localparam logic [6:0] lui_op       = 7'b0110111;
    localparam logic [6:0] auipc_op     = 7'b0010111;
    localparam logic [6:0] jal_op       = 7'b1101111;
    localparam logic [6:0] jalr_op      = 7'b1100111;
    localparam logic [6:0] branch_op    = 7'b1100011;
    localparam logic [6:0] load_op      = 7'b0000011;
    localparam logic [6:0] store_op     = 7'b0100011;
    localparam logic [6:0] misc_mem_op  = 7'b0001111;
    localparam logic [6:0] system_op    = 7'b1110011;
    localparam logic [6:0] amo_op       = 7'b0101111;

    localparam logic [6:0] f7_base        = 7'b0000000;
    localparam logic [6:0] f7_alt         = 7'b0100000;
    localparam logic [6:0] f7_muldiv      = 7'b0000001;
    localparam logic [6:0] f7_sfence_vma  = 7'b0001001;

    // Sub and sra reuse the add and srl codes
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_mul  = 3'b000;
    localparam logic [2:0] f3_div  = 3'b100;
    localparam logic [2:0] f3_divu = 3'b101;
    localparam logic [2:0] f3_rem  = 3'b110;
    localparam logic [2:0] f3_remu = 3'b111;

    localparam logic [2:0] f3_jalr = 3'b000;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_ld  = 3'b011;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_lwu = 3'b110;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;
    localparam logic [2:0] f3_sd  = 3'b011;

    localparam logic [2:0] f3_fence   = 3'b000;
    localparam logic [2:0] f3_fence_i = 3'b001;

    localparam logic [2:0] f3_priv   = 3'b000;
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrs  = 3'b010;
    localparam logic [2:0] f3_csrrc  = 3'b011;
    localparam logic [2:0] f3_csrrwi = 3'b101;
    localparam logic [2:0] f3_csrrsi = 3'b110;
    localparam logic [2:0] f3_csrrci = 3'b111;

    // Privileged instructions with no free fields
    localparam logic [instr_width-1:0] ecall_instr  = 32'h0000_0073;
    localparam logic [instr_width-1:0] ebreak_instr = 32'h0010_0073;
    localparam logic [instr_width-1:0] dret_instr   = 32'h7b20_0073;
    localparam logic [instr_width-1:0] mret_instr   = 32'h3020_0073;
    localparam logic [instr_width-1:0] sret_instr   = 32'h1020_0073;
    localparam logic [instr_width-1:0] wfi_instr    = 32'h1050_0073;

    typedef enum logic [1:0] {
        e_instr_access_fault = 2'd0,
        e_instr_page_fault   = 2'd1,
        e_itlb_miss          = 2'd2
    } fe_exc_e;

    typedef struct packed {
        rv64_instr_s instr;
        logic        exc_v;
        fe_exc_e     exc_code;
    } fetch_entry_s;

    // Upper bits name the pipe group
    typedef enum logic [5:0] {
        e_int_op_add = 6'h00, e_int_op_sub = 6'h01, e_int_op_sll = 6'h02,
        e_int_op_srl = 6'h03, e_int_op_sra = 6'h04, e_int_op_slt = 6'h05,
        e_int_op_sltu = 6'h06, e_int_op_xor = 6'h07, e_int_op_or = 6'h08,
        e_int_op_and = 6'h09, e_int_op_pass_src2 = 6'h0a,
        e_mul_op_mul = 6'h10, e_mul_op_div = 6'h11, e_mul_op_divu = 6'h12,
        e_mul_op_rem = 6'h13, e_mul_op_remu = 6'h14,
        e_ctrl_op_jal = 6'h18, e_ctrl_op_jalr = 6'h19, e_ctrl_op_beq = 6'h1a,
        e_ctrl_op_bne = 6'h1b, e_ctrl_op_blt = 6'h1c, e_ctrl_op_bge = 6'h1d,
        e_ctrl_op_bltu = 6'h1e, e_ctrl_op_bgeu = 6'h1f,
        e_lb = 6'h20, e_lh = 6'h21, e_lw = 6'h22, e_lbu = 6'h23, e_lhu = 6'h24,
        e_lwu = 6'h25, e_ld = 6'h26, e_sb = 6'h28, e_sh = 6'h29, e_sw = 6'h2a,
        e_sd = 6'h2b, e_fencei = 6'h2f,
        e_ecall = 6'h30, e_ebreak = 6'h31, e_dret = 6'h32, e_mret = 6'h33,
        e_sret = 6'h34, e_wfi = 6'h35, e_sfence_vma = 6'h36,
        e_csrrw = 6'h38, e_csrrs = 6'h39, e_csrrc = 6'h3a,
        e_csrrwi = 6'h3b, e_csrrsi = 6'h3c, e_csrrci = 6'h3d
    } fu_op_e;

    typedef enum logic {
        e_src1_is_rs1 = 1'b0,
        e_src1_is_pc  = 1'b1
    } src1_e;

    typedef enum logic {
        e_src2_is_rs2 = 1'b0,
        e_src2_is_imm = 1'b1
    } src2_e;

    typedef enum logic {
        e_baddr_is_pc  = 1'b0,
        e_baddr_is_rs1 = 1'b1
    } baddr_e;

    typedef struct packed {
        logic ctrl_v;
        logic int_v;
        logic mem_v;
        logic mul_v;
        logic long_v;
        logic sys_v;
    } pipe_sel_s;

    typedef struct packed {
        logic       instr_v;
        pipe_sel_s  pipe_sel;
        logic       irf_w_v;
        logic       dcache_r_v;
        logic       dcache_w_v;
        logic       csr_r_v;
        logic       csr_w_v;
        logic       mem_v;
        logic       csr_v;
        logic       serial_v;
        logic       opw_v;
        fu_op_e     fu_op;
        src1_e      src1_sel;
        src2_e      src2_sel;
        baddr_e     baddr_sel;
        logic       illegal_instr;
        logic       instr_access_fault;
        logic       instr_page_fault;
        logic       itlb_miss;
        logic [2:0] pad;
    } decode_s;

endpackage
